// ==== Makefile ====
VERILATOR ?= verilator
TOP       := tb_exu
RTL_TOP   := exu_top
FILELIST  := tb.f
FLAGS     := --binary --timing -j 0
LINTFLAGS := --lint-only -Wall --timing
BUILD_DIR := obj_dir
SOURCES   := $(wildcard hdl/*.sv hdl/*.svh test/*.sv)

.PHONY: all run lint clean

all: run

run: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// ==== hdl/exu_alu.sv ====
// alu with add, sub, compare, logic, shift and immediate copy, plus branch flags
`timescale 1ns/10ps
`default_nettype none
`include "exu_consts.svh"

module exu_alu (
  input  exu_pkg::xlen_t    i_src_a,
  input  exu_pkg::xlen_t    i_src_b,
  input  exu_pkg::alu_ctr_t i_alu_ctr,
  input  logic              i_word_cut,
  input  exu_pkg::xlen_t    i_imm,
  output exu_pkg::xlen_t    o_result,
  output logic              o_zero,
  output logic              o_less
);

  import exu_pkg::*;

  xlen_t       diff;
  logic        borrow;
  logic        ovf;
  logic        less_s;
  logic        less_u;
  logic [5:0]  shamt;
  xlen_t       sra_full;
  logic [31:0] sra_word;

  // borrow out of the subtract is the unsigned compare
  assign {borrow, diff} = {1'b0, i_src_a} - {1'b0, i_src_b};
  assign ovf    = (i_src_a[63] ^ i_src_b[63]) & (i_src_a[63] ^ diff[63]);
  assign less_s = diff[63] ^ ovf;
  assign less_u = borrow;

  assign o_zero = ~|diff;
  assign o_less = (i_alu_ctr == `ALU_SLTU) ? less_u : less_s;

  // 5-bit amount in word mode
  assign shamt = i_word_cut ? {1'b0, i_src_b[4:0]} : i_src_b[5:0];

  assign sra_full = $signed(i_src_a) >>> shamt;
  assign sra_word = $signed(i_src_a[31:0]) >>> shamt[4:0];

  always_comb begin
    case (i_alu_ctr)
      `ALU_ADD:  o_result = i_src_a + i_src_b;
      `ALU_SUB:  o_result = diff;
      `ALU_SLT:  o_result = {63'b0, less_s};
      `ALU_SLTU: o_result = {63'b0, less_u};
      `ALU_XOR:  o_result = i_src_a ^ i_src_b;
      `ALU_AND:  o_result = i_src_a & i_src_b;
      `ALU_OR:   o_result = i_src_a | i_src_b;
      `ALU_SLL:  o_result = i_src_a << shamt;
      `ALU_SRL:  o_result = i_src_a >> shamt;
      `ALU_SRA:  o_result = i_word_cut ? {{32{sra_word[31]}}, sra_word} : sra_full;
      `ALU_COPY: o_result = i_imm;
      // mul and div come from the muldiv unit
      default:   o_result = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== hdl/exu_branch.sv ====
// branch decision and next pc adder
`timescale 1ns/10ps
`default_nettype none
`include "exu_consts.svh"

module exu_branch (
  input  exu_pkg::branch_t i_branch,
  input  logic             i_zero,
  input  logic             i_less,
  input  exu_pkg::xlen_t   i_pc,
  input  exu_pkg::xlen_t   i_rs1,
  input  exu_pkg::xlen_t   i_imm,
  output exu_pkg::xlen_t   o_next_pc
);

  import exu_pkg::*;

  logic  taken;
  xlen_t base;
  xlen_t offset;

  always_comb begin
    case (i_branch)
      `BR_JAL,
      `BR_JALR: taken = 1'b1;
      `BR_BEQ:  taken = i_zero;
      `BR_BNE:  taken = ~i_zero;
      `BR_BLT:  taken = i_less;
      `BR_BGE:  taken = ~i_less;
      default:  taken = 1'b0;
    endcase
  end

  // jalr is relative to rs1
  assign base      = (i_branch == `BR_JALR) ? i_rs1 : i_pc;
  assign offset    = taken ? i_imm : `EXU_XLEN'(4);
  assign o_next_pc = base + offset;

endmodule

`default_nettype wire

// ==== hdl/exu_consts.svh ====
// width, depth, credit, alu, branch, load and status code macros for the execute unit
`ifndef EXU_CONSTS_SVH
`define EXU_CONSTS_SVH

`define EXU_XLEN        64
`define EXU_DEPTH       2
`define EXU_OUT_CREDITS 4
`define EXU_CREDIT_W    3

// alu operation codes
`define ALU_ADD  5'b00000
`define ALU_SUB  5'b00001
`define ALU_SLT  5'b00010
`define ALU_SLTU 5'b00011
`define ALU_XOR  5'b00100
`define ALU_AND  5'b00101
`define ALU_OR   5'b00110
`define ALU_SLL  5'b00111
`define ALU_SRL  5'b01000
`define ALU_SRA  5'b01001
`define ALU_MUL  5'b01010
`define ALU_DIV  5'b01011
`define ALU_DIVU 5'b01100
`define ALU_REM  5'b01101
`define ALU_REMU 5'b01110
`define ALU_COPY 5'b01111

// source b select
`define ALUB_RS2  2'b00
`define ALUB_IMM  2'b01
`define ALUB_FOUR 2'b10

// branch kinds
`define BR_NONE 3'b000
`define BR_JAL  3'b001
`define BR_JALR 3'b010
`define BR_BEQ  3'b100
`define BR_BNE  3'b101
`define BR_BLT  3'b110
`define BR_BGE  3'b111

// load extension kinds
`define LD_LB  3'b000
`define LD_LBU 3'b001
`define LD_LH  3'b010
`define LD_LHU 3'b011
`define LD_LW  3'b100
`define LD_LWU 3'b101
`define LD_LD  3'b110

// execute status
`define EX_EBREAK  4'b1110
`define EX_INVALID 4'b1111

`endif

// ==== hdl/exu_ctrl.sv ====
// execute unit control with stage valids, credit counter, credit return and halt status
`timescale 1ns/10ps
`default_nettype none
`include "exu_consts.svh"

module exu_ctrl (
  input  logic             i_clk,
  input  logic             i_arst_n,
  input  logic             i_in_valid,
  input  logic             i_out_credit,
  input  exu_pkg::ex_ctr_t i_ex_ctr,
  output logic             o_op_load,
  output logic             o_res_load,
  output logic             o_out_valid,
  output logic             o_in_credit,
  output logic             o_halt,
  output logic             o_abort
);

  localparam logic [`EXU_CREDIT_W-1:0] CREDIT_INIT = `EXU_CREDIT_W'(`EXU_OUT_CREDITS);

  logic                     op_valid;
  logic                     res_valid;
  logic [`EXU_CREDIT_W-1:0] credits;
  logic                     send;
  logic                     stop_code;
  logic                     bad_code;
  logic                     halt_q;
  logic                     abort_q;

  // result stage leaves only while a downstream credit is held
  assign send        = res_valid && (credits != '0);
  assign o_out_valid = send;
  assign o_in_credit = send;

  assign o_op_load  = i_in_valid;
  assign o_res_load = op_valid && (!res_valid || send);

  assign bad_code  = (i_ex_ctr == `EX_INVALID);
  assign stop_code = bad_code || (i_ex_ctr == `EX_EBREAK);

  // status shows up in the send cycle itself
  assign o_halt  = halt_q || (send && stop_code);
  assign o_abort = abort_q || (send && bad_code);

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      op_valid  <= 1'b0;
      res_valid <= 1'b0;
      credits   <= CREDIT_INIT;
      halt_q    <= 1'b0;
      abort_q   <= 1'b0;
    end else begin
      if (i_in_valid) begin
        op_valid <= 1'b1;
      end else if (o_res_load) begin
        op_valid <= 1'b0;
      end
      if (o_res_load) begin
        res_valid <= 1'b1;
      end else if (send) begin
        res_valid <= 1'b0;
      end
      // a returned credit in a send cycle cancels out
      case ({send, i_out_credit})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits;
      endcase
      halt_q  <= o_halt;
      abort_q <= o_abort;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/exu_muldiv.sv ====
// combinational multiply, divide and remainder with risc-v corner results
`timescale 1ns/10ps
`default_nettype none
`include "exu_consts.svh"

module exu_muldiv (
  input  exu_pkg::xlen_t    i_src_a,
  input  exu_pkg::xlen_t    i_src_b,
  input  exu_pkg::alu_ctr_t i_alu_ctr,
  output exu_pkg::xlen_t    o_result,
  output logic              o_is_md
);

  import exu_pkg::*;

  localparam xlen_t MOST_NEG = {1'b1, {(`EXU_XLEN-1){1'b0}}};

  xlen_t prod;
  xlen_t sdiv_raw;
  xlen_t srem_raw;
  xlen_t quot_s;
  xlen_t quot_u;
  xlen_t rem_s;
  xlen_t rem_u;
  logic  div_zero;
  logic  div_ovf;

  assign div_zero = (i_src_b == '0);
  assign div_ovf  = (i_src_a == MOST_NEG) && (i_src_b == '1);

  // low half is the same for signed and unsigned
  assign prod     = i_src_a * i_src_b;
  assign sdiv_raw = $signed(i_src_a) / $signed(i_src_b);
  assign srem_raw = $signed(i_src_a) % $signed(i_src_b);

  assign quot_s = div_zero ? '1 : (div_ovf ? i_src_a : sdiv_raw);
  assign rem_s  = div_zero ? i_src_a : (div_ovf ? '0 : srem_raw);
  assign quot_u = div_zero ? '1 : i_src_a / i_src_b;
  assign rem_u  = div_zero ? i_src_a : i_src_a % i_src_b;

  always_comb begin
    o_is_md = 1'b1;
    case (i_alu_ctr)
      `ALU_MUL:  o_result = prod;
      `ALU_DIV:  o_result = quot_s;
      `ALU_DIVU: o_result = quot_u;
      `ALU_REM:  o_result = rem_s;
      `ALU_REMU: o_result = rem_u;
      default: begin
        o_result = '0;
        o_is_md  = 1'b0;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== hdl/exu_operand.sv ====
// operand stage with word cut, source a/b select and instruction capture
`timescale 1ns/10ps
`default_nettype none
`include "exu_consts.svh"

module exu_operand (
  input  logic                i_clk,
  input  logic                i_arst_n,
  input  logic                i_load,
  input  exu_pkg::xlen_t      i_rs1,
  input  exu_pkg::xlen_t      i_rs2,
  input  exu_pkg::xlen_t      i_imm,
  input  exu_pkg::xlen_t      i_pc,
  input  exu_pkg::xlen_t      i_rdata,
  input  logic                i_alua_src,
  input  exu_pkg::alub_sel_t  i_alub_src,
  input  exu_pkg::alu_ctr_t   i_alu_ctr,
  input  logic                i_word_cut,
  input  exu_pkg::branch_t    i_branch,
  input  exu_pkg::mem_op_t    i_mem_op,
  input  logic                i_mem_to_reg,
  input  logic                i_sel_csr,
  input  exu_pkg::ex_ctr_t    i_ex_ctr,
  output exu_pkg::xlen_t      o_src_a,
  output exu_pkg::xlen_t      o_src_b,
  output exu_pkg::xlen_t      o_rs1,
  output exu_pkg::xlen_t      o_rs2,
  output exu_pkg::xlen_t      o_imm,
  output exu_pkg::xlen_t      o_pc,
  output exu_pkg::xlen_t      o_rdata,
  output exu_pkg::alu_ctr_t   o_alu_ctr,
  output logic                o_word_cut,
  output exu_pkg::branch_t    o_branch,
  output exu_pkg::mem_op_t    o_mem_op,
  output logic                o_mem_to_reg,
  output logic                o_sel_csr,
  output exu_pkg::ex_ctr_t    o_ex_ctr
);

  import exu_pkg::*;

  xlen_t rs1_cut;
  xlen_t rs2_cut;
  xlen_t imm_cut;
  xlen_t src_a;
  xlen_t src_b;

  // word mode keeps the low word, zero extended
  assign rs1_cut = i_word_cut ? {32'b0, i_rs1[31:0]} : i_rs1;
  assign rs2_cut = i_word_cut ? {32'b0, i_rs2[31:0]} : i_rs2;
  assign imm_cut = i_word_cut ? {32'b0, i_imm[31:0]} : i_imm;

  assign src_a = i_alua_src ? i_pc : rs1_cut;

  always_comb begin
    case (i_alub_src)
      `ALUB_IMM:  src_b = imm_cut;
      `ALUB_FOUR: src_b = `EXU_XLEN'(4);
      default:    src_b = rs2_cut;
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (i_load) begin
      o_src_a <= src_a;
      o_src_b <= src_b;
      o_rs1   <= i_rs1;
      o_rs2   <= i_rs2;
      o_imm   <= i_imm;
      o_pc    <= i_pc;
      o_rdata <= i_rdata;
    end
  end

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_alu_ctr    <= `ALU_ADD;
      o_word_cut   <= 1'b0;
      o_branch     <= `BR_NONE;
      o_mem_op     <= `LD_LD;
      o_mem_to_reg <= 1'b0;
      o_sel_csr    <= 1'b0;
      o_ex_ctr     <= '0;
    end else if (i_load) begin
      o_alu_ctr    <= i_alu_ctr;
      o_word_cut   <= i_word_cut;
      o_branch     <= i_branch;
      o_mem_op     <= i_mem_op;
      o_mem_to_reg <= i_mem_to_reg;
      o_sel_csr    <= i_sel_csr;
      o_ex_ctr     <= i_ex_ctr;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/exu_pkg.sv ====
// vector types for the execute unit datapath and control fields
`default_nettype none
`include "exu_consts.svh"

package exu_pkg;

  // data word, also pc, immediate and load data
  typedef logic [`EXU_XLEN-1:0] xlen_t;

  typedef logic [4:0] alu_ctr_t;

  // rs2, immediate or constant 4
  typedef logic [1:0] alub_sel_t;

  // signedness of blt/bge comes from the alu code
  typedef logic [2:0] branch_t;

  typedef logic [2:0] mem_op_t;

  typedef logic [3:0] ex_ctr_t;

endpackage

`default_nettype wire

// ==== hdl/exu_top.sv ====
// execute unit top level
`timescale 1ns/10ps
`default_nettype none

module exu_top (
  input  logic               i_clk,
  input  logic               i_arst_n,
  input  logic               i_in_valid,
  input  exu_pkg::xlen_t     i_rs1,
  input  exu_pkg::xlen_t     i_rs2,
  input  exu_pkg::xlen_t     i_imm,
  input  exu_pkg::xlen_t     i_pc,
  input  exu_pkg::xlen_t     i_rdata,
  input  logic               i_alua_src,
  input  exu_pkg::alub_sel_t i_alub_src,
  input  exu_pkg::alu_ctr_t  i_alu_ctr,
  input  logic               i_word_cut,
  input  exu_pkg::branch_t   i_branch,
  input  exu_pkg::mem_op_t   i_mem_op,
  input  logic               i_mem_to_reg,
  input  logic               i_sel_csr,
  input  exu_pkg::ex_ctr_t   i_ex_ctr,
  input  logic               i_out_credit,
  output logic               o_in_credit,
  output logic               o_out_valid,
  output exu_pkg::xlen_t     o_alu_result,
  output exu_pkg::xlen_t     o_next_pc,
  output exu_pkg::xlen_t     o_bus_w,
  output logic               o_halt,
  output logic               o_abort
);

  import exu_pkg::*;

  logic      op_load;
  logic      res_load;
  xlen_t     src_a;
  xlen_t     src_b;
  xlen_t     op_rs1;
  xlen_t     op_rs2;
  xlen_t     op_imm;
  xlen_t     op_pc;
  xlen_t     op_rdata;
  alu_ctr_t  op_alu_ctr;
  logic      op_word_cut;
  branch_t   op_branch;
  mem_op_t   op_mem_op;
  logic      op_mem_to_reg;
  logic      op_sel_csr;
  ex_ctr_t   op_ex_ctr;
  xlen_t     alu_result;
  logic      alu_zero;
  logic      alu_less;
  xlen_t     md_result;
  logic      is_md;
  xlen_t     next_pc;
  ex_ctr_t   res_ex_ctr;

  exu_ctrl u_ctrl (
    .i_clk        (i_clk),
    .i_arst_n     (i_arst_n),
    .i_in_valid   (i_in_valid),
    .i_out_credit (i_out_credit),
    .i_ex_ctr     (res_ex_ctr),
    .o_op_load    (op_load),
    .o_res_load   (res_load),
    .o_out_valid  (o_out_valid),
    .o_in_credit  (o_in_credit),
    .o_halt       (o_halt),
    .o_abort      (o_abort)
  );

  exu_operand u_operand (
    .i_clk        (i_clk),
    .i_arst_n     (i_arst_n),
    .i_load       (op_load),
    .i_rs1        (i_rs1),
    .i_rs2        (i_rs2),
    .i_imm        (i_imm),
    .i_pc         (i_pc),
    .i_rdata      (i_rdata),
    .i_alua_src   (i_alua_src),
    .i_alub_src   (i_alub_src),
    .i_alu_ctr    (i_alu_ctr),
    .i_word_cut   (i_word_cut),
    .i_branch     (i_branch),
    .i_mem_op     (i_mem_op),
    .i_mem_to_reg (i_mem_to_reg),
    .i_sel_csr    (i_sel_csr),
    .i_ex_ctr     (i_ex_ctr),
    .o_src_a      (src_a),
    .o_src_b      (src_b),
    .o_rs1        (op_rs1),
    .o_rs2        (op_rs2),
    .o_imm        (op_imm),
    .o_pc         (op_pc),
    .o_rdata      (op_rdata),
    .o_alu_ctr    (op_alu_ctr),
    .o_word_cut   (op_word_cut),
    .o_branch     (op_branch),
    .o_mem_op     (op_mem_op),
    .o_mem_to_reg (op_mem_to_reg),
    .o_sel_csr    (op_sel_csr),
    .o_ex_ctr     (op_ex_ctr)
  );

  exu_alu u_alu (
    .i_src_a    (src_a),
    .i_src_b    (src_b),
    .i_alu_ctr  (op_alu_ctr),
    .i_word_cut (op_word_cut),
    .i_imm      (op_imm),
    .o_result   (alu_result),
    .o_zero     (alu_zero),
    .o_less     (alu_less)
  );

  exu_muldiv u_muldiv (
    .i_src_a   (src_a),
    .i_src_b   (src_b),
    .i_alu_ctr (op_alu_ctr),
    .o_result  (md_result),
    .o_is_md   (is_md)
  );

  exu_branch u_branch (
    .i_branch  (op_branch),
    .i_zero    (alu_zero),
    .i_less    (alu_less),
    .i_pc      (op_pc),
    .i_rs1     (op_rs1),
    .i_imm     (op_imm),
    .o_next_pc (next_pc)
  );

  exu_wb u_wb (
    .i_clk        (i_clk),
    .i_arst_n     (i_arst_n),
    .i_load       (res_load),
    .i_alu_result (alu_result),
    .i_md_result  (md_result),
    .i_is_md      (is_md),
    .i_word_cut   (op_word_cut),
    .i_next_pc    (next_pc),
    .i_rdata      (op_rdata),
    .i_mem_op     (op_mem_op),
    .i_mem_to_reg (op_mem_to_reg),
    .i_sel_csr    (op_sel_csr),
    .i_rs2        (op_rs2),
    .i_ex_ctr     (op_ex_ctr),
    .o_alu_result (o_alu_result),
    .o_next_pc    (o_next_pc),
    .o_bus_w      (o_bus_w),
    .o_ex_ctr     (res_ex_ctr)
  );

endmodule

`default_nettype wire

// ==== hdl/exu_wb.sv ====
// word result extension, load extension, write-back select and result register
`timescale 1ns/10ps
`default_nettype none
`include "exu_consts.svh"

module exu_wb (
  input  logic              i_clk,
  input  logic              i_arst_n,
  input  logic              i_load,
  input  exu_pkg::xlen_t    i_alu_result,
  input  exu_pkg::xlen_t    i_md_result,
  input  logic              i_is_md,
  input  logic              i_word_cut,
  input  exu_pkg::xlen_t    i_next_pc,
  input  exu_pkg::xlen_t    i_rdata,
  input  exu_pkg::mem_op_t  i_mem_op,
  input  logic              i_mem_to_reg,
  input  logic              i_sel_csr,
  input  exu_pkg::xlen_t    i_rs2,
  input  exu_pkg::ex_ctr_t  i_ex_ctr,
  output exu_pkg::xlen_t    o_alu_result,
  output exu_pkg::xlen_t    o_next_pc,
  output exu_pkg::xlen_t    o_bus_w,
  output exu_pkg::ex_ctr_t  o_ex_ctr
);

  import exu_pkg::*;

  xlen_t result;
  xlen_t result_ext;
  xlen_t load_ext;
  xlen_t bus_w;

  assign result = i_is_md ? i_md_result : i_alu_result;

  // word ops sign extend the low word
  assign result_ext = i_word_cut ? {{32{result[31]}}, result[31:0]} : result;

  always_comb begin
    case (i_mem_op)
      `LD_LB:  load_ext = {{56{i_rdata[7]}}, i_rdata[7:0]};
      `LD_LBU: load_ext = {56'b0, i_rdata[7:0]};
      `LD_LH:  load_ext = {{48{i_rdata[15]}}, i_rdata[15:0]};
      `LD_LHU: load_ext = {48'b0, i_rdata[15:0]};
      `LD_LW:  load_ext = {{32{i_rdata[31]}}, i_rdata[31:0]};
      `LD_LWU: load_ext = {32'b0, i_rdata[31:0]};
      default: load_ext = i_rdata;
    endcase
  end

  // csr moves write the raw rs2
  assign bus_w = i_mem_to_reg ? load_ext : (i_sel_csr ? i_rs2 : result_ext);

  always_ff @(posedge i_clk) begin
    if (i_load) begin
      o_alu_result <= result_ext;
      o_next_pc    <= i_next_pc;
      o_bus_w      <= bus_w;
    end
  end

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_ex_ctr <= '0;
    end else if (i_load) begin
      o_ex_ctr <= i_ex_ctr;
    end
  end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+hdl
hdl/exu_pkg.sv
hdl/exu_ctrl.sv
hdl/exu_operand.sv
hdl/exu_alu.sv
hdl/exu_muldiv.sv
hdl/exu_branch.sv
hdl/exu_wb.sv
hdl/exu_top.sv
test/tb_exu.sv

// ==== test/tb_exu.sv ====
// testbench for the execute unit with random items, reference model and credit driver and sink
`timescale 1ns/10ps
`default_nettype none
`include "exu_consts.svh"

module tb_exu;

  import exu_pkg::*;

  localparam int    CLK_PERIOD  = 100;
  localparam int    N_ITEMS     = 420;
  localparam int    EBREAK_IDX  = 100;
  localparam int    INVALID_IDX = 350;
  localparam xlen_t MOST_NEG    = {1'b1, {(`EXU_XLEN-1){1'b0}}};

  logic      i_clk;
  logic      i_arst_n;
  logic      i_in_valid;
  xlen_t     i_rs1;
  xlen_t     i_rs2;
  xlen_t     i_imm;
  xlen_t     i_pc;
  xlen_t     i_rdata;
  logic      i_alua_src;
  alub_sel_t i_alub_src;
  alu_ctr_t  i_alu_ctr;
  logic      i_word_cut;
  branch_t   i_branch;
  mem_op_t   i_mem_op;
  logic      i_mem_to_reg;
  logic      i_sel_csr;
  ex_ctr_t   i_ex_ctr;
  logic      i_out_credit;
  logic      o_in_credit;
  logic      o_out_valid;
  xlen_t     o_alu_result;
  xlen_t     o_next_pc;
  xlen_t     o_bus_w;
  logic      o_halt;
  logic      o_abort;

  integer  seed = 32'hcd54;
  int      cyc = 0;
  int      item_idx = 0;
  int      up_credits = `EXU_DEPTH;
  int      sink_credits = `EXU_OUT_CREDITS;
  int      out_count = 0;
  int      in_count = 0;
  logic    halt_seen = 1'b0;
  logic    abort_seen = 1'b0;
  // sink behavior and latency expectation
  logic    hold = 1'b0;
  logic    fast = 1'b0;
  logic    tight = 1'b0;

  xlen_t   exp_alu_q[$];
  xlen_t   exp_npc_q[$];
  xlen_t   exp_bus_q[$];
  ex_ctr_t code_q[$];
  int      in_cyc_q[$];
  logic    tight_q[$];
  int      ret_q[$];

  exu_top i_dut (
    .i_clk        (i_clk),
    .i_arst_n     (i_arst_n),
    .i_in_valid   (i_in_valid),
    .i_rs1        (i_rs1),
    .i_rs2        (i_rs2),
    .i_imm        (i_imm),
    .i_pc         (i_pc),
    .i_rdata      (i_rdata),
    .i_alua_src   (i_alua_src),
    .i_alub_src   (i_alub_src),
    .i_alu_ctr    (i_alu_ctr),
    .i_word_cut   (i_word_cut),
    .i_branch     (i_branch),
    .i_mem_op     (i_mem_op),
    .i_mem_to_reg (i_mem_to_reg),
    .i_sel_csr    (i_sel_csr),
    .i_ex_ctr     (i_ex_ctr),
    .i_out_credit (i_out_credit),
    .o_in_credit  (o_in_credit),
    .o_out_valid  (o_out_valid),
    .o_alu_result (o_alu_result),
    .o_next_pc    (o_next_pc),
    .o_bus_w      (o_bus_w),
    .o_halt       (o_halt),
    .o_abort      (o_abort)
  );

  initial begin
    i_clk = 1'b0;
    forever #(CLK_PERIOD/2) i_clk = ~i_clk;
  end

  always @(posedge i_clk) cyc <= cyc + 1;

  function automatic logic [31:0] next_rand();
    next_rand = $random(seed);
  endfunction

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display(">>> FAIL");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_xlen(input string what, input xlen_t got, input xlen_t exp);
    if (got !== exp) begin
      report_failure($sformatf("ERROR at %0t: %s is %h, expected %h", $time, what, got, exp));
    end
  endtask

  task automatic check_flag(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      report_failure($sformatf("ERROR at %0t: %s is %b, expected %b", $time, what, got, exp));
    end
  endtask

  // reference alu and mul/div, with the word rule applied to the result
  function automatic xlen_t model_result(input xlen_t a, input xlen_t b, input xlen_t imm,
                                         input alu_ctr_t ctr, input logic word);
    logic [5:0] sh;
    xlen_t      r;
    sh = word ? {1'b0, b[4:0]} : b[5:0];
    case (ctr)
      `ALU_ADD:  r = a + b;
      `ALU_SUB:  r = a - b;
      `ALU_SLT:  r = xlen_t'($signed(a) < $signed(b));
      `ALU_SLTU: r = xlen_t'(a < b);
      `ALU_XOR:  r = a ^ b;
      `ALU_AND:  r = a & b;
      `ALU_OR:   r = a | b;
      `ALU_SLL:  r = a << sh;
      `ALU_SRL:  r = a >> sh;
      `ALU_SRA: begin
        if (word) begin
          r = xlen_t'($signed(a[31:0]));
        end else begin
          r = a;
        end
        r = $signed(r) >>> sh;
      end
      `ALU_MUL:  r = a * b;
      `ALU_DIV: begin
        if (b == '0) r = '1;
        else if (a == MOST_NEG && b == '1) r = a;
        else r = $signed(a) / $signed(b);
      end
      `ALU_DIVU: r = (b == '0) ? '1 : a / b;
      `ALU_REM: begin
        if (b == '0) r = a;
        else if (a == MOST_NEG && b == '1) r = '0;
        else r = $signed(a) % $signed(b);
      end
      `ALU_REMU: r = (b == '0) ? a : a % b;
      `ALU_COPY: r = imm;
      default:   r = '0;
    endcase
    if (word) begin
      r = xlen_t'($signed(r[31:0]));
    end
    return r;
  endfunction

  function automatic xlen_t model_next_pc(input branch_t br, input alu_ctr_t ctr, input xlen_t a,
                                          input xlen_t b, input xlen_t pc, input xlen_t rs1,
                                          input xlen_t imm);
    logic lt;
    logic take;
    lt = (ctr == `ALU_SLTU) ? (a < b) : ($signed(a) < $signed(b));
    case (br)
      `BR_JAL, `BR_JALR: take = 1'b1;
      `BR_BEQ: take = (a == b);
      `BR_BNE: take = (a != b);
      `BR_BLT: take = lt;
      `BR_BGE: take = !lt;
      default: take = 1'b0;
    endcase
    return ((br == `BR_JALR) ? rs1 : pc) + (take ? imm : xlen_t'(4));
  endfunction

  function automatic xlen_t model_load(input mem_op_t op, input xlen_t d);
    case (op)
      `LD_LB:  return xlen_t'($signed(d[7:0]));
      `LD_LBU: return xlen_t'(d[7:0]);
      `LD_LH:  return xlen_t'($signed(d[15:0]));
      `LD_LHU: return xlen_t'(d[15:0]);
      `LD_LW:  return xlen_t'($signed(d[31:0]));
      `LD_LWU: return xlen_t'(d[31:0]);
      default: return d;
    endcase
  endfunction

  // random instruction onto the inputs, expected results into the queues
  task automatic load_item(input int idx);
    logic [31:0] r;
    xlen_t       rs1;
    xlen_t       rs2;
    xlen_t       imm;
    xlen_t       a;
    xlen_t       b;
    xlen_t       res;
    r   = next_rand();
    rs1 = {next_rand(), next_rand()};
    rs2 = {next_rand(), next_rand()};
    imm = {next_rand(), next_rand()};
    i_pc         = {next_rand(), next_rand()};
    i_rdata      = {next_rand(), next_rand()};
    i_word_cut   = (r[4:3] == 2'b00);
    i_alua_src   = r[5];
    i_alub_src   = r[7:6];
    i_alu_ctr    = {1'b0, r[11:8]};
    i_branch     = r[14:12];
    i_mem_op     = r[17:15];
    i_mem_to_reg = (r[19:18] == 2'b00);
    i_sel_csr    = (r[21:20] == 2'b00);
    // zero divisor, overflow divide and equal operands
    if (r[2:0] <= 3'd2) begin
      i_alua_src = 1'b0;
      i_alub_src = `ALUB_RS2;
      case (r[2:0])
        3'd0: begin
          rs2 = '0;
          // div, divu, rem or remu
          i_alu_ctr = `ALU_DIV + alu_ctr_t'(r[9:8]);
        end
        3'd1: begin
          rs1 = MOST_NEG;
          rs2 = '1;
          i_word_cut = 1'b0;
          i_alu_ctr = `ALU_DIV + alu_ctr_t'(r[9:8]);
        end
        default: rs2 = rs1;
      endcase
    end
    if (idx == EBREAK_IDX) i_ex_ctr = `EX_EBREAK;
    else if (idx == INVALID_IDX) i_ex_ctr = `EX_INVALID;
    else i_ex_ctr = ex_ctr_t'(r[25:22] % 4'd14);
    i_rs1 = rs1;
    i_rs2 = rs2;
    i_imm = imm;

    a = i_alua_src ? i_pc : (i_word_cut ? xlen_t'(rs1[31:0]) : rs1);
    case (i_alub_src)
      `ALUB_IMM:  b = i_word_cut ? xlen_t'(imm[31:0]) : imm;
      `ALUB_FOUR: b = xlen_t'(4);
      default:    b = i_word_cut ? xlen_t'(rs2[31:0]) : rs2;
    endcase
    res = model_result(a, b, imm, i_alu_ctr, i_word_cut);
    exp_alu_q.push_back(res);
    exp_npc_q.push_back(model_next_pc(i_branch, i_alu_ctr, a, b, i_pc, rs1, imm));
    if (i_mem_to_reg) exp_bus_q.push_back(model_load(i_mem_op, i_rdata));
    else if (i_sel_csr) exp_bus_q.push_back(rs2);
    else exp_bus_q.push_back(res);
    code_q.push_back(i_ex_ctr);
    in_cyc_q.push_back(cyc);
    tight_q.push_back(tight);
  endtask

  // sends only while holding an upstream credit
  task automatic run_items(input int count, input int idle_pct);
    int          sent;
    logic [31:0] r;
    sent = 0;
    while (sent < count) begin
      @(posedge i_clk);
      #1;
      i_in_valid = 1'b0;
      r = next_rand();
      if (up_credits > 0 && (r % 100) >= idle_pct) begin
        load_item(item_idx);
        i_in_valid = 1'b1;
        up_credits--;
        item_idx++;
        sent++;
      end
    end
    @(posedge i_clk);
    #1;
    i_in_valid = 1'b0;
  endtask

  task automatic wait_idle();
    while (!(exp_alu_q.size() == 0 && sink_credits == `EXU_OUT_CREDITS)) begin
      @(negedge i_clk);
      #1;
    end
  endtask

  // sink returns at most one credit per cycle
  initial begin
    i_out_credit = 1'b0;
    forever begin
      @(posedge i_clk);
      #1;
      i_out_credit = 1'b0;
      if (!hold && ret_q.size() > 0 && ret_q[0] <= cyc) begin
        i_out_credit = 1'b1;
        void'(ret_q.pop_front());
      end
    end
  end

  always @(negedge i_clk) begin : monitor
    ex_ctr_t code;
    int      lat;
    logic    exp_halt;
    logic    exp_abort;
    logic    exact;
    if (i_arst_n) begin
      exp_halt  = halt_seen;
      exp_abort = abort_seen;
      if (o_out_valid) begin
        if (exp_alu_q.size() == 0) report_failure("output appeared with no item in flight");
        if (sink_credits == 0) report_failure("output sent without a downstream credit");
        sink_credits--;
        ret_q.push_back(cyc + 1 + (fast ? 0 : int'(next_rand() % 6)));
        check_xlen("o_alu_result", o_alu_result, exp_alu_q.pop_front());
        check_xlen("o_next_pc", o_next_pc, exp_npc_q.pop_front());
        check_xlen("o_bus_w", o_bus_w, exp_bus_q.pop_front());
        code  = code_q.pop_front();
        lat   = cyc - in_cyc_q.pop_front();
        exact = tight_q.pop_front();
        if ((exact && lat != 2) || lat < 2) begin
          report_failure($sformatf("item %0d left after %0d cycles", out_count, lat));
        end
        exp_halt  = exp_halt | (code == `EX_EBREAK) | (code == `EX_INVALID);
        exp_abort = exp_abort | (code == `EX_INVALID);
        out_count++;
      end
      check_flag("o_halt", o_halt, exp_halt);
      check_flag("o_abort", o_abort, exp_abort);
      halt_seen  = exp_halt;
      abort_seen = exp_abort;
      if (o_in_credit) begin
        in_count++;
        up_credits++;
        if (up_credits > `EXU_DEPTH) report_failure("more upstream credits returned than granted");
      end
      if (in_count != out_count) report_failure("credit returns do not match outputs");
      if (i_out_credit) sink_credits++;
    end
  end

  initial begin
    #(N_ITEMS * 40 * CLK_PERIOD);
    $display("watchdog expired before all items came out");
    $display(">>> FAIL");
    $fatal(1, "timeout");
  end

  initial begin
    i_arst_n     = 1'b0;
    i_in_valid   = 1'b0;
    i_rs1        = '0;
    i_rs2        = '0;
    i_imm        = '0;
    i_pc         = '0;
    i_rdata      = '0;
    i_alua_src   = 1'b0;
    i_alub_src   = `ALUB_RS2;
    i_alu_ctr    = `ALU_ADD;
    i_word_cut   = 1'b0;
    i_branch     = `BR_NONE;
    i_mem_op     = `LD_LD;
    i_mem_to_reg = 1'b0;
    i_sel_csr    = 1'b0;
    i_ex_ctr     = '0;
    repeat (3) @(posedge i_clk);
    #1;
    i_arst_n = 1'b1;
    check_flag("o_out_valid after reset", o_out_valid, 1'b0);
    check_flag("o_in_credit after reset", o_in_credit, 1'b0);

    run_items(200, 30);
    wait_idle();
    // back to back with prompt credit return
    tight = 1'b1;
    fast  = 1'b1;
    run_items(60, 0);
    wait_idle();
    tight = 1'b0;
    fast  = 1'b0;
    hold  = 1'b1;
    fork
      run_items(20, 0);
      begin
        repeat (30) @(negedge i_clk);
        hold = 1'b0;
      end
    join
    run_items(140, 20);
    wait_idle();

    if (out_count == N_ITEMS && in_count == N_ITEMS && halt_seen && abort_seen) begin
      $display(">>> PASS");
      $finish;
    end else begin
      $display("run ended with %0d outputs of %0d items", out_count, N_ITEMS);
      $display(">>> FAIL");
      $fatal(1, "incomplete run");
    end
  end

endmodule

`default_nettype wire
